//--- source/maze_pkg.sv
package maze_pkg;

   // Codes stored in the maze RAM, one per tile
   typedef enum logic [3:0] {
      tile_empty      = 4'd0,
      tile_wall_1     = 4'd1,
      tile_wall_2     = 4'd2,
      tile_gate_right = 4'd3,
      tile_gate_left  = 4'd4,
      tile_gate_up    = 4'd5,
      tile_gate_down  = 4'd6,
      tile_bomb       = 4'd7
   } tile_e;

   // Move directions, screen y grows downwards
   typedef enum logic [1:0] {
      dir_up,
      dir_down,
      dir_right,
      dir_left
   } dir_e;

   // Per-frame sequencer states
   typedef enum logic [3:0] {
      st_idle,
      st_move_check,
      st_move_read,
      st_move_wait,
      st_move_judge,
      st_move_step,
      st_bomb_check,
      st_bomb_read,
      st_bomb_wait,
      st_bomb_judge,
      st_done
   } seq_state_e;

   // Playfield in tiles
   localparam int GRID_COLS = 25;
   localparam int GRID_ROWS = 17;

   // Tile edge in pixels and tile index width
   localparam int TILE_SIZE  = 32;
   localparam int TILE_SHIFT = $clog2(TILE_SIZE);
   localparam int IDX_W      = $clog2((GRID_COLS > GRID_ROWS) ? GRID_COLS : GRID_ROWS);

   // Sub-pixel fraction bits and signed pixel coordinate width
   localparam int FRAC_BITS = 4;
   localparam int POS_W     = 11;

   typedef logic signed [POS_W-1:0] pos_t;

   // Row index in the upper half, column index in the lower half
   typedef logic [2*IDX_W-1:0] maze_addr_t;

   // Start positions in pixels
   localparam int P1_START_X = 128;
   localparam int P1_START_Y = 128;
   localparam int P2_START_X = 448;
   localparam int P2_START_Y = 448;

endpackage

//--- source/move_decode.sv
module move_decode
(
   input  logic                 up,
   input  logic                 down,
   input  logic                 left,
   input  logic                 right,
   input  logic                 drop,
   input  maze_pkg::pos_t       pos_x,
   input  maze_pkg::pos_t       pos_y,
   output logic                 move_req,
   output maze_pkg::dir_e       move_dir,
   output maze_pkg::maze_addr_t target_addr,
   output maze_pkg::maze_addr_t bomb_addr
);
   import maze_pkg::*;

   // Pixel position of the tile one step away
   pos_t dest_x;
   pos_t dest_y;

   // Position shifted by half a tile, for rounding
   pos_t near_x;
   pos_t near_y;

   // Key priority up, down, right, left
   always_comb
   begin
      move_req = up | down | right | left;
      move_dir = dir_up;
      dest_x   = pos_x;
      dest_y   = pos_y;
      if (up)
      begin
         move_dir = dir_up;
         dest_y   = pos_y - pos_t'(TILE_SIZE);
      end
      else if (down)
      begin
         move_dir = dir_down;
         dest_y   = pos_y + pos_t'(TILE_SIZE);
      end
      else if (right)
      begin
         move_dir = dir_right;
         dest_x   = pos_x + pos_t'(TILE_SIZE);
      end
      else if (left)
      begin
         move_dir = dir_left;
         dest_x   = pos_x - pos_t'(TILE_SIZE);
      end
   end

   // Divide by the tile size to get tile indices
   assign target_addr = {dest_y[TILE_SHIFT +: IDX_W], dest_x[TILE_SHIFT +: IDX_W]};

   // Tile the player mostly covers
   assign near_x = pos_x + pos_t'(TILE_SIZE / 2);
   assign near_y = pos_y + pos_t'(TILE_SIZE / 2);

   // Address stays at zero while the drop key is released
   assign bomb_addr = drop ? {near_y[TILE_SHIFT +: IDX_W], near_x[TILE_SHIFT +: IDX_W]} : '0;

endmodule

//--- source/player_motion.sv
module player_motion
#(
   parameter int SPEED   = 32,
   parameter int START_X = maze_pkg::P1_START_X,
   parameter int START_Y = maze_pkg::P1_START_Y
)
(
   input  logic           clk,
   input  logic           reset_n,
   input  logic           start,
   input  logic           step,
   input  maze_pkg::dir_e dir,
   output maze_pkg::pos_t pos_x,
   output maze_pkg::pos_t pos_y,
   output logic           moving
);
   import maze_pkg::*;

   // Fixed point, pixels with FRAC_BITS fraction bits
   localparam int FX_W = POS_W + FRAC_BITS;

   typedef logic signed [FX_W-1:0] fx_t;

   localparam fx_t TILE_FX    = fx_t'(TILE_SIZE << FRAC_BITS);
   localparam fx_t SPEED_FX   = fx_t'(SPEED);
   localparam fx_t START_X_FX = fx_t'(START_X << FRAC_BITS);
   localparam fx_t START_Y_FX = fx_t'(START_Y << FRAC_BITS);

   fx_t  fx_x;
   fx_t  fx_y;
   fx_t  goal_x;
   fx_t  goal_y;
   fx_t  vel_x;
   fx_t  vel_y;
   fx_t  next_x;
   fx_t  next_y;
   logic arrive;

   // Candidate position after one step
   assign next_x = fx_x + vel_x;
   assign next_y = fx_y + vel_y;

   // Only the axis with a nonzero velocity can reach its goal
   assign arrive = ((vel_x > 0) && (next_x >= goal_x)) ||
                   ((vel_x < 0) && (next_x <= goal_x)) ||
                   ((vel_y > 0) && (next_y >= goal_y)) ||
                   ((vel_y < 0) && (next_y <= goal_y));

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         fx_x   <= START_X_FX;
         fx_y   <= START_Y_FX;
         moving <= 1'b0;
      end
      else if (start)
         moving <= 1'b1;
      else if (step && moving)
      begin
         // Snap onto the tile once the step would reach or pass it
         if (arrive)
         begin
            fx_x   <= goal_x;
            fx_y   <= goal_y;
            moving <= 1'b0;
         end
         else
         begin
            fx_x <= next_x;
            fx_y <= next_y;
         end
      end
   end

   // Goal one tile away and velocity along that axis
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         goal_x <= fx_x;
         goal_y <= fx_y;
         vel_x  <= '0;
         vel_y  <= '0;
         case (dir)
            dir_up:
            begin
               goal_y <= fx_y - TILE_FX;
               vel_y  <= -SPEED_FX;
            end
            dir_down:
            begin
               goal_y <= fx_y + TILE_FX;
               vel_y  <= SPEED_FX;
            end
            dir_right:
            begin
               goal_x <= fx_x + TILE_FX;
               vel_x  <= SPEED_FX;
            end
            default:
            begin
               goal_x <= fx_x - TILE_FX;
               vel_x  <= -SPEED_FX;
            end
         endcase
      end
   end

   // Whole pixels only
   assign pos_x = fx_x[FX_W-1:FRAC_BITS];
   assign pos_y = fx_y[FX_W-1:FRAC_BITS];

endmodule

//--- source/maze_sequencer.sv
module maze_sequencer
(
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 eof,
   input  logic                 p1_move_req,
   input  logic                 p2_move_req,
   input  maze_pkg::dir_e       p1_move_dir,
   input  maze_pkg::dir_e       p2_move_dir,
   input  maze_pkg::maze_addr_t p1_target_addr,
   input  maze_pkg::maze_addr_t p2_target_addr,
   input  maze_pkg::maze_addr_t p1_bomb_addr,
   input  maze_pkg::maze_addr_t p2_bomb_addr,
   input  logic                 p1_drop,
   input  logic                 p2_drop,
   input  logic                 p1_moving,
   input  logic                 p2_moving,
   input  logic [3:0]           ram_rdata,
   output logic                 p1_start,
   output logic                 p1_step,
   output logic                 p2_start,
   output logic                 p2_step,
   output maze_pkg::maze_addr_t ram_raddr,
   output maze_pkg::maze_addr_t ram_waddr,
   output logic [3:0]           ram_wdata,
   output logic                 ram_we
);
   import maze_pkg::*;

   seq_state_e state;

   // Current player, 0 for player 1
   logic cur;
   // Direction taken at the check, used by the gate rules
   dir_e dir_q;

   // Inputs of the current player
   logic       cur_req;
   logic       cur_moving;
   logic       cur_drop;
   dir_e       cur_dir;
   maze_addr_t cur_target;
   maze_addr_t cur_bomb;

   // Judge results for the tile just read
   logic  move_ok;
   logic  gate_hit;
   tile_e flip_code;

   assign cur_req    = cur ? p2_move_req    : p1_move_req;
   assign cur_moving = cur ? p2_moving      : p1_moving;
   assign cur_drop   = cur ? p2_drop        : p1_drop;
   assign cur_dir    = cur ? p2_move_dir    : p1_move_dir;
   assign cur_target = cur ? p2_target_addr : p1_target_addr;
   assign cur_bomb   = cur ? p2_bomb_addr   : p1_bomb_addr;

   // Walls block, gates only pass in their own direction
   always_comb
   begin
      move_ok   = 1'b1;
      gate_hit  = 1'b0;
      flip_code = tile_empty;
      case (tile_e'(ram_rdata))
         tile_wall_1, tile_wall_2:
            move_ok = 1'b0;
         tile_gate_right:
         begin
            gate_hit  = 1'b1;
            move_ok   = (dir_q == dir_right);
            flip_code = tile_gate_left;
         end
         tile_gate_left:
         begin
            gate_hit  = 1'b1;
            move_ok   = (dir_q == dir_left);
            flip_code = tile_gate_right;
         end
         tile_gate_up:
         begin
            gate_hit  = 1'b1;
            move_ok   = (dir_q == dir_up);
            flip_code = tile_gate_down;
         end
         tile_gate_down:
         begin
            gate_hit  = 1'b1;
            move_ok   = (dir_q == dir_down);
            flip_code = tile_gate_up;
         end
         // Empty, bomb and unknown codes let the player through
         default:
            move_ok = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state     <= st_idle;
         cur       <= 1'b0;
         dir_q     <= dir_up;
         p1_start  <= 1'b0;
         p1_step   <= 1'b0;
         p2_start  <= 1'b0;
         p2_step   <= 1'b0;
         ram_raddr <= '0;
         ram_waddr <= '0;
         ram_wdata <= '0;
         ram_we    <= 1'b0;
      end
      else
      begin
         // Strobes last one cycle
         p1_start <= 1'b0;
         p1_step  <= 1'b0;
         p2_start <= 1'b0;
         p2_step  <= 1'b0;
         ram_we   <= 1'b0;
         case (state)
            st_idle:
               if (eof)
               begin
                  cur   <= 1'b0;
                  state <= st_move_check;
               end
            st_move_check:
               // A moving player ignores its keys
               if (cur_moving)
                  state <= st_move_step;
               else if (cur_req)
               begin
                  dir_q <= cur_dir;
                  state <= st_move_read;
               end
               else
               begin
                  cur   <= ~cur;
                  state <= cur ? st_bomb_check : st_move_check;
               end
            st_move_read:
            begin
               ram_raddr <= cur_target;
               state     <= st_move_wait;
            end
            // RAM read latency
            st_move_wait:
               state <= st_move_judge;
            st_move_judge:
               if (move_ok)
               begin
                  p1_start <= ~cur;
                  p2_start <= cur;
                  // Passing a gate turns it around
                  if (gate_hit)
                  begin
                     ram_we    <= 1'b1;
                     ram_waddr <= ram_raddr;
                     ram_wdata <= flip_code;
                  end
                  state <= st_move_step;
               end
               else
               begin
                  cur   <= ~cur;
                  state <= cur ? st_bomb_check : st_move_check;
               end
            st_move_step:
            begin
               p1_step <= ~cur;
               p2_step <= cur;
               cur     <= ~cur;
               state   <= cur ? st_bomb_check : st_move_check;
            end
            st_bomb_check:
               if (cur_drop)
                  state <= st_bomb_read;
               else
               begin
                  cur   <= ~cur;
                  state <= cur ? st_done : st_bomb_check;
               end
            st_bomb_read:
            begin
               ram_raddr <= cur_bomb;
               state     <= st_bomb_wait;
            end
            st_bomb_wait:
               state <= st_bomb_judge;
            st_bomb_judge:
            begin
               // Bombs only go onto empty tiles
               if (tile_e'(ram_rdata) == tile_empty)
               begin
                  ram_we    <= 1'b1;
                  ram_waddr <= ram_raddr;
                  ram_wdata <= tile_bomb;
               end
               cur   <= ~cur;
               state <= cur ? st_done : st_bomb_check;
            end
            st_done:
               state <= st_idle;
            default:
               state <= st_idle;
         endcase
      end
   end

endmodule

//--- source/maze_controller.sv
module maze_controller
#(
   parameter int SPEED_P1 = 32,
   parameter int SPEED_P2 = 3
)
(
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 eof,
   input  logic                 p1_up,
   input  logic                 p1_down,
   input  logic                 p1_left,
   input  logic                 p1_right,
   input  logic                 p1_drop,
   input  logic                 p2_up,
   input  logic                 p2_down,
   input  logic                 p2_left,
   input  logic                 p2_right,
   input  logic                 p2_drop,
   output maze_pkg::pos_t       player1_x,
   output maze_pkg::pos_t       player1_y,
   output maze_pkg::pos_t       player2_x,
   output maze_pkg::pos_t       player2_y,
   output maze_pkg::maze_addr_t ram_raddr,
   output maze_pkg::maze_addr_t ram_waddr,
   output logic [3:0]           ram_wdata,
   output logic                 ram_we,
   input  logic [3:0]           ram_rdata
);
   import maze_pkg::*;

   // Decoder results per player
   logic       p1_move_req;
   logic       p2_move_req;
   dir_e       p1_move_dir;
   dir_e       p2_move_dir;
   maze_addr_t p1_target_addr;
   maze_addr_t p2_target_addr;
   maze_addr_t p1_bomb_addr;
   maze_addr_t p2_bomb_addr;

   // Motion handshake with the sequencer
   logic p1_start;
   logic p1_step;
   logic p1_moving;
   logic p2_start;
   logic p2_step;
   logic p2_moving;

   move_decode u_decode_p1 (
      .up          (p1_up),
      .down        (p1_down),
      .left        (p1_left),
      .right       (p1_right),
      .drop        (p1_drop),
      .pos_x       (player1_x),
      .pos_y       (player1_y),
      .move_req    (p1_move_req),
      .move_dir    (p1_move_dir),
      .target_addr (p1_target_addr),
      .bomb_addr   (p1_bomb_addr)
   );

   move_decode u_decode_p2 (
      .up          (p2_up),
      .down        (p2_down),
      .left        (p2_left),
      .right       (p2_right),
      .drop        (p2_drop),
      .pos_x       (player2_x),
      .pos_y       (player2_y),
      .move_req    (p2_move_req),
      .move_dir    (p2_move_dir),
      .target_addr (p2_target_addr),
      .bomb_addr   (p2_bomb_addr)
   );

   // Direction comes straight from the decoder at the start pulse
   player_motion #(
      .SPEED   (SPEED_P1),
      .START_X (P1_START_X),
      .START_Y (P1_START_Y)
   ) u_motion_p1 (
      .clk     (clk),
      .reset_n (reset_n),
      .start   (p1_start),
      .step    (p1_step),
      .dir     (p1_move_dir),
      .pos_x   (player1_x),
      .pos_y   (player1_y),
      .moving  (p1_moving)
   );

   player_motion #(
      .SPEED   (SPEED_P2),
      .START_X (P2_START_X),
      .START_Y (P2_START_Y)
   ) u_motion_p2 (
      .clk     (clk),
      .reset_n (reset_n),
      .start   (p2_start),
      .step    (p2_step),
      .dir     (p2_move_dir),
      .pos_x   (player2_x),
      .pos_y   (player2_y),
      .moving  (p2_moving)
   );

   maze_sequencer u_sequencer (
      .clk            (clk),
      .reset_n        (reset_n),
      .eof            (eof),
      .p1_move_req    (p1_move_req),
      .p2_move_req    (p2_move_req),
      .p1_move_dir    (p1_move_dir),
      .p2_move_dir    (p2_move_dir),
      .p1_target_addr (p1_target_addr),
      .p2_target_addr (p2_target_addr),
      .p1_bomb_addr   (p1_bomb_addr),
      .p2_bomb_addr   (p2_bomb_addr),
      .p1_drop        (p1_drop),
      .p2_drop        (p2_drop),
      .p1_moving      (p1_moving),
      .p2_moving      (p2_moving),
      .ram_rdata      (ram_rdata),
      .p1_start       (p1_start),
      .p1_step        (p1_step),
      .p2_start       (p2_start),
      .p2_step        (p2_step),
      .ram_raddr      (ram_raddr),
      .ram_waddr      (ram_waddr),
      .ram_wdata      (ram_wdata),
      .ram_we         (ram_we)
   );

endmodule

//--- tests/maze_ram_model.sv
module maze_ram_model
#(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 4
)
(
   input  logic              clk,
   input  logic [ADDR_W-1:0] raddr,
   output logic [DATA_W-1:0] rdata,
   input  logic [ADDR_W-1:0] waddr,
   input  logic [DATA_W-1:0] wdata,
   input  logic              we
);

   localparam int DEPTH = 1 << ADDR_W;

   // Tile codes, loaded by the testbench through hierarchical writes
   logic [DATA_W-1:0] mem [0:DEPTH-1];

   // Write port, sampled with address and data on the same edge
   always @(posedge clk)
   begin
      if (we)
         mem[waddr] <= wdata;
   end

   // Registered read
   // Address registered by the sequencer, data valid one edge later
   always @(posedge clk)
   begin
      rdata <= mem[raddr];
   end

endmodule

//--- tests/tb_maze_controller.sv
module tb_maze_controller;
   import maze_pkg::*;

   localparam int SPEED_P1      = 32;
   localparam int SPEED_P2      = 3;
   localparam int CLK_HALF      = 4;
   localparam int RESET_CYCLES  = 3;
   localparam int PASS_CYCLES   = 24;
   localparam int QUIET_CYCLES  = 2;
   localparam int PASS_TIMEOUT  = 64;
   localparam int GAP_MIN       = 24;
   localparam int GAP_MAX       = 40;
   localparam int MAZE_DEPTH    = 1024;
   localparam int TILE_PX       = 32;
   localparam int TILE_BITS     = 5;
   localparam int IDX_MASK      = 31;
   localparam int FRAC          = 4;
   localparam int RNG_SEED      = 32'h2e9d40ff;

   logic       clk;
   logic       reset_n;
   logic       eof;
   logic       p1_up;
   logic       p1_down;
   logic       p1_left;
   logic       p1_right;
   logic       p1_drop;
   logic       p2_up;
   logic       p2_down;
   logic       p2_left;
   logic       p2_right;
   logic       p2_drop;
   pos_t       player1_x;
   pos_t       player1_y;
   pos_t       player2_x;
   pos_t       player2_y;
   maze_addr_t ram_raddr;
   maze_addr_t ram_waddr;
   logic [3:0] ram_wdata;
   logic [3:0] ram_rdata;
   logic       ram_we;

   // Reference model, positions in sixteenths of a pixel
   int         fx [2];
   int         fy [2];
   int         gx [2];
   int         gy [2];
   int         vx [2];
   int         vy [2];
   bit         mv [2];
   int         speed [2];
   logic [3:0] exp_mem [MAZE_DEPTH];
   int         exp_writes;

   // Bookkeeping
   int          errors;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;
   int          writes_seen;
   int          writes_base;
   int unsigned seed_value;

   maze_controller #(
      .SPEED_P1 (SPEED_P1),
      .SPEED_P2 (SPEED_P2)
   ) u_dut (
      .clk       (clk),
      .reset_n   (reset_n),
      .eof       (eof),
      .p1_up     (p1_up),
      .p1_down   (p1_down),
      .p1_left   (p1_left),
      .p1_right  (p1_right),
      .p1_drop   (p1_drop),
      .p2_up     (p2_up),
      .p2_down   (p2_down),
      .p2_left   (p2_left),
      .p2_right  (p2_right),
      .p2_drop   (p2_drop),
      .player1_x (player1_x),
      .player1_y (player1_y),
      .player2_x (player2_x),
      .player2_y (player2_y),
      .ram_raddr (ram_raddr),
      .ram_waddr (ram_waddr),
      .ram_wdata (ram_wdata),
      .ram_we    (ram_we),
      .ram_rdata (ram_rdata)
   );

   maze_ram_model u_ram (
      .clk   (clk),
      .raddr (ram_raddr),
      .rdata (ram_rdata),
      .waddr (ram_waddr),
      .wdata (ram_wdata),
      .we    (ram_we)
   );

   always #CLK_HALF clk = ~clk;

   // Count RAM writes away from the active edge
   always @(negedge clk)
   begin
      if (reset_n && ram_we)
         writes_seen++;
   end

   // Write strobe lasts one cycle
   assert property (@(posedge clk) disable iff (!reset_n) ram_we |=> !ram_we)
   else
   begin
      errors++;
      $display("CHECK FAILED at time %0t: ram_we high for two cycles", $time);
   end

   // Nothing ever writes an empty tile
   assert property (@(posedge clk) disable iff (!reset_n) ram_we |-> (ram_wdata != tile_empty))
   else
   begin
      errors++;
      $display("CHECK FAILED at time %0t: empty code written to the maze", $time);
   end

   task automatic expect_eq(input int got, input int exp, input string what);
      assert (got == exp)
      else
      begin
         errors++;
         $display("CHECK FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic abort_run(input string reason);
      $display("ERROR at time %0t: %s", $time, reason);
      $display("Simulation failed");
      $finish;
   endtask

   // Row index above column index
   function automatic int tile_addr(input int x, input int y);
      return (((y >>> TILE_BITS) & IDX_MASK) << TILE_BITS) | ((x >>> TILE_BITS) & IDX_MASK);
   endfunction

   task automatic release_keys();
      p1_up    = 1'b0;
      p1_down  = 1'b0;
      p1_left  = 1'b0;
      p1_right = 1'b0;
      p1_drop  = 1'b0;
      p2_up    = 1'b0;
      p2_down  = 1'b0;
      p2_left  = 1'b0;
      p2_right = 1'b0;
      p2_drop  = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      int count;
      count = 0;
      while (count < n)
      begin
         @(posedge clk);
         #1;
         count++;
      end
   endtask

   task automatic clear_maze();
      int i;
      for (i = 0; i < MAZE_DEPTH; i++)
      begin
         u_ram.mem[i] = tile_empty;
         exp_mem[i]   = tile_empty;
      end
   endtask

   task automatic set_tile(input int addr, input logic [3:0] code);
      u_ram.mem[addr] = code;
      exp_mem[addr]   = code;
   endtask

   task automatic apply_reset();
      int n;
      release_keys();
      eof     = 1'b0;
      reset_n = 1'b0;
      n       = 0;
      while (n < RESET_CYCLES)
      begin
         @(posedge clk);
         n++;
      end
      #1;
      reset_n = 1'b1;
      // Model back at the start tiles
      fx[0] = P1_START_X << FRAC;
      fy[0] = P1_START_Y << FRAC;
      fx[1] = P2_START_X << FRAC;
      fy[1] = P2_START_Y << FRAC;
      mv[0] = 1'b0;
      mv[1] = 1'b0;
      exp_writes = 0;
   endtask

   // Pulse eof, then wait out the pass
   task automatic run_frame();
      int         cycles;
      int         quiet;
      int         gap;
      maze_addr_t last_raddr;
      @(posedge clk);
      #1;
      eof = 1'b1;
      @(posedge clk);
      #1;
      eof        = 1'b0;
      cycles     = 1;
      quiet      = 0;
      last_raddr = ram_raddr;
      while ((cycles < PASS_CYCLES) || (quiet < QUIET_CYCLES))
      begin
         @(posedge clk);
         #1;
         cycles++;
         if (ram_we || (ram_raddr != last_raddr))
            quiet = 0;
         else
            quiet++;
         last_raddr = ram_raddr;
         if (cycles > PASS_TIMEOUT)
            abort_run("frame pass still busy with the maze RAM after the timeout");
      end
      // Random spacing to the next eof
      gap = $urandom_range(GAP_MAX, GAP_MIN) - cycles;
      idle_cycles(gap);
   endtask

   // One sub-pixel step, snap when the goal is reached or passed
   function automatic void advance_position(input int p);
      int nx;
      int ny;
      bit arrive;
      nx = fx[p] + vx[p];
      ny = fy[p] + vy[p];
      arrive = ((vx[p] > 0) && (nx >= gx[p])) || ((vx[p] < 0) && (nx <= gx[p])) ||
               ((vy[p] > 0) && (ny >= gy[p])) || ((vy[p] < 0) && (ny <= gy[p]));
      if (arrive)
      begin
         fx[p] = gx[p];
         fy[p] = gy[p];
         mv[p] = 1'b0;
      end
      else
      begin
         fx[p] = nx;
         fy[p] = ny;
      end
   endfunction

   task automatic judge_player_move(input int p);
      bit         up;
      bit         down;
      bit         left;
      bit         right;
      int         dx;
      int         dy;
      int         addr;
      bit         ok;
      bit         flips;
      logic [3:0] flip;
      up    = p ? p2_up : p1_up;
      down  = p ? p2_down : p1_down;
      left  = p ? p2_left : p1_left;
      right = p ? p2_right : p1_right;
      dx    = 0;
      dy    = 0;
      ok    = 1'b1;
      flips = 1'b0;
      flip  = tile_empty;
      if (mv[p])
         advance_position(p);
      else if (up || down || left || right)
      begin
         // Up wins, then down, right, left
         if (up)
            dy = -1;
         else if (down)
            dy = 1;
         else if (right)
            dx = 1;
         else
            dx = -1;
         addr = tile_addr((fx[p] >>> FRAC) + dx * TILE_PX, (fy[p] >>> FRAC) + dy * TILE_PX);
         case (exp_mem[addr])
            tile_wall_1, tile_wall_2:
               ok = 1'b0;
            tile_gate_right:
            begin
               ok    = (dx == 1);
               flips = 1'b1;
               flip  = tile_gate_left;
            end
            tile_gate_left:
            begin
               ok    = (dx == -1);
               flips = 1'b1;
               flip  = tile_gate_right;
            end
            tile_gate_up:
            begin
               ok    = (dy == -1);
               flips = 1'b1;
               flip  = tile_gate_down;
            end
            tile_gate_down:
            begin
               ok    = (dy == 1);
               flips = 1'b1;
               flip  = tile_gate_up;
            end
            default:
               ok = 1'b1;
         endcase
         if (ok)
         begin
            if (flips)
            begin
               exp_mem[addr] = flip;
               exp_writes++;
            end
            gx[p] = fx[p] + dx * (TILE_PX << FRAC);
            gy[p] = fy[p] + dy * (TILE_PX << FRAC);
            vx[p] = dx * speed[p];
            vy[p] = dy * speed[p];
            mv[p] = 1'b1;
            advance_position(p);
         end
      end
   endtask

   // Bomb on the nearest tile, only if empty
   task automatic place_bomb(input int p);
      int addr;
      addr = tile_addr((fx[p] >>> FRAC) + TILE_PX / 2, (fy[p] >>> FRAC) + TILE_PX / 2);
      if ((p ? p2_drop : p1_drop) && (exp_mem[addr] == tile_empty))
      begin
         exp_mem[addr] = tile_bomb;
         exp_writes++;
      end
   endtask

   // Moves first, then bombs on the new positions
   task automatic predict_pass();
      judge_player_move(0);
      judge_player_move(1);
      place_bomb(0);
      place_bomb(1);
   endtask

   task automatic compare_state();
      int i;
      int bad;
      expect_eq(player1_x, fx[0] >>> FRAC, "player 1 x");
      expect_eq(player1_y, fy[0] >>> FRAC, "player 1 y");
      expect_eq(player2_x, fx[1] >>> FRAC, "player 2 x");
      expect_eq(player2_y, fy[1] >>> FRAC, "player 2 y");
      expect_eq(writes_seen - writes_base, exp_writes, "RAM write count");
      bad = -1;
      for (i = 0; i < MAZE_DEPTH; i++)
      begin
         if ((bad < 0) && (u_ram.mem[i] !== exp_mem[i]))
            bad = i;
      end
      assert (bad < 0)
      else
      begin
         errors++;
         $display("CHECK FAILED at time %0t: maze tile %0d holds %0d, expected %0d",
                  $time, bad, u_ram.mem[bad], exp_mem[bad]);
      end
   endtask

   task automatic prepare_test();
      errors_at_start = errors;
      clear_maze();
      apply_reset();
      writes_base = writes_seen;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == errors_at_start)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: %0d checks failed", name, errors - errors_at_start);
      end
   endtask

   task automatic after_reset();
      prepare_test();
      expect_eq(ram_we, 0, "ram_we after reset");
      expect_eq(ram_raddr, 0, "ram_raddr after reset");
      expect_eq(ram_waddr, 0, "ram_waddr after reset");
      // No eof, so nothing may move or write
      idle_cycles(2 * PASS_CYCLES);
      expect_eq(player1_x, P1_START_X, "player 1 start x");
      expect_eq(player1_y, P1_START_Y, "player 1 start y");
      expect_eq(player2_x, P2_START_X, "player 2 start x");
      expect_eq(player2_y, P2_START_Y, "player 2 start y");
      compare_state();
      finish_test("reset");
   endtask

   task automatic free_movement();
      int frame;
      prepare_test();
      p2_down = 1'b1;
      for (frame = 1; frame <= 171; frame++)
      begin
         p1_right = (frame <= 16);
         run_frame();
         predict_pass();
         compare_state();
         if (frame == 16)
            expect_eq(player1_x, P1_START_X + TILE_PX, "player 1 x at frame 16");
         if (frame == 170)
            expect_eq(player2_y, P2_START_Y + TILE_PX - 1, "player 2 y at frame 170");
      end
      expect_eq(player2_y, P2_START_Y + TILE_PX, "player 2 y at frame 171");
      finish_test("free movement");
   endtask

   task automatic blocked_moves();
      int frame;
      prepare_test();
      set_tile(tile_addr(P1_START_X + TILE_PX, P1_START_Y), tile_wall_1);
      set_tile(tile_addr(P2_START_X, P2_START_Y + TILE_PX), tile_wall_2);
      p1_right = 1'b1;
      p2_down  = 1'b1;
      run_frame();
      predict_pass();
      compare_state();
      expect_eq(player1_x, P1_START_X, "player 1 x against a wall");
      expect_eq(player2_y, P2_START_Y, "player 2 y against a wall");
      expect_eq(writes_seen - writes_base, 0, "writes after blocked moves");
      // Up and right together, up wins
      release_keys();
      p1_up    = 1'b1;
      p1_right = 1'b1;
      run_frame();
      predict_pass();
      compare_state();
      expect_eq(player1_y, P1_START_Y - SPEED_P1 / 16, "player 1 y with up and right");
      // New keys are ignored until the tile is reached
      release_keys();
      p1_left = 1'b1;
      p1_down = 1'b1;
      for (frame = 2; frame <= 16; frame++)
      begin
         run_frame();
         predict_pass();
         compare_state();
      end
      expect_eq(player1_x, P1_START_X, "player 1 x after the turn attempt");
      expect_eq(player1_y, P1_START_Y - TILE_PX, "player 1 y after the turn attempt");
      finish_test("blocked moves");
   endtask

   task automatic gate_passage();
      int frame;
      int gate_east;
      int gate_north;
      prepare_test();
      gate_east  = tile_addr(P1_START_X + TILE_PX, P1_START_Y);
      gate_north = tile_addr(P2_START_X, P2_START_Y - TILE_PX);
      set_tile(gate_east, tile_gate_right);
      set_tile(gate_north, tile_gate_down);
      p1_right = 1'b1;
      p2_up    = 1'b1;
      for (frame = 1; frame <= 16; frame++)
      begin
         run_frame();
         predict_pass();
         compare_state();
         if (frame == 1)
            expect_eq(u_ram.mem[gate_east], tile_gate_left, "gate code after passing");
      end
      expect_eq(player1_x, P1_START_X + TILE_PX, "player 1 x past the gate");
      expect_eq(player2_y, P2_START_Y, "player 2 y at a wrong-way gate");
      expect_eq(u_ram.mem[gate_north], tile_gate_down, "untouched gate code");
      finish_test("gates");
   endtask

   task automatic bomb_drops();
      int frame;
      int p1_tile;
      int p2_tile;
      prepare_test();
      p1_right = 1'b1;
      for (frame = 1; frame <= 9; frame++)
      begin
         run_frame();
         predict_pass();
         compare_state();
      end
      // Drop while still sliding towards the next tile
      release_keys();
      p1_drop = 1'b1;
      run_frame();
      predict_pass();
      compare_state();
      p1_tile = tile_addr((fx[0] >>> FRAC) + TILE_PX / 2, (fy[0] >>> FRAC) + TILE_PX / 2);
      expect_eq(u_ram.mem[p1_tile], tile_bomb, "bomb on the nearest tile");
      expect_eq(writes_seen - writes_base, 1, "writes after the first drop");
      // Second drop lands on the same bomb, player 2 drops on an empty tile
      p2_drop = 1'b1;
      run_frame();
      predict_pass();
      compare_state();
      p2_tile = tile_addr(P2_START_X + TILE_PX / 2, P2_START_Y + TILE_PX / 2);
      expect_eq(u_ram.mem[p2_tile], tile_bomb, "player 2 bomb");
      expect_eq(writes_seen - writes_base, 2, "writes after the second drop");
      finish_test("bombs");
   endtask

   initial
   begin
      seed_value   = $urandom(RNG_SEED);
      clk          = 1'b0;
      reset_n      = 1'b0;
      eof          = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      writes_seen  = 0;
      writes_base  = 0;
      speed[0]     = SPEED_P1;
      speed[1]     = SPEED_P2;
      release_keys();
      after_reset();
      free_movement();
      blocked_moves();
      gate_passage();
      bomb_drops();
      $display("%0d tests run, %0d tests failed, %0d checks failed",
               tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- maze_controller.f
source/maze_pkg.sv
source/move_decode.sv
source/player_motion.sv
source/maze_sequencer.sv
source/maze_controller.sv
tests/maze_ram_model.sv
tests/tb_maze_controller.sv

//--- Bender.yml
package:
  name: maze_controller

sources:
  - files:
      - source/maze_pkg.sv
      - source/move_decode.sv
      - source/player_motion.sv
      - source/maze_sequencer.sv
      - source/maze_controller.sv
  - target: test
    files:
      - tests/maze_ram_model.sv
      - tests/tb_maze_controller.sv
